// ==== logic/matrix_pkg.sv ====
/* shared geometry, timing constants and types for the led matrix scan controller
   imported by wildcard in every module that needs a type or a constant */
package matrix_pkg;

    // panel geometry, 64 x 32 shifted out as two 16 row halves
    localparam int PIXEL_WIDTH = 64;
    localparam int SUBPANEL_ROWS = 16;

    // bits per colour channel, shown by binary-coded modulation
    localparam int COLOR_BITS = 4;

    // output enable cycles per unit of bit-plane weight
    localparam int OE_UNIT_CYCLES = 8;
    // the next shift-out may start this many cycles before the window closes
    localparam int BRIGHTNESS_STATE_TIMEOUT_OVERLAP = 4;

    // derived widths
    localparam int COL_ADDR_BITS = $clog2(PIXEL_WIDTH);
    localparam int ROW_SUB_BITS = $clog2(SUBPANEL_ROWS);
    // one extra bit so the load window can hold the full column count
    localparam int LOAD_COUNTER_WIDTH = COL_ADDR_BITS + 1;
    // wide enough for the heaviest plane times the unit
    localparam int OE_COUNTER_WIDTH = $clog2((1 << (COLOR_BITS - 1)) * OE_UNIT_CYCLES + 1);

    typedef logic [COL_ADDR_BITS-1:0] col_addr_t;
    typedef logic [ROW_SUB_BITS-1:0] row_subpanel_addr_t;
    // full row index, top bit picks the lower half
    typedef logic [ROW_SUB_BITS:0] row_addr_t;
    // one-hot, the set bit is the plane being shown
    typedef logic [COLOR_BITS-1:0] brightness_level_t;
    typedef logic [COLOR_BITS-1:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_t;

    // one bit per channel as it goes to the panel pins
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } panel_rgb_t;

    // scan starts on the most significant plane
    localparam brightness_level_t BRIGHTNESS_MASK_RESET =
        brightness_level_t'(1 << (COLOR_BITS - 1));

endpackage

// ==== logic/timeout.sv ====
/* loadable down-counter, loads on start and counts to zero
   running stays high while the count is non-zero */
module timeout #(
    parameter int COUNTER_WIDTH = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // a new start always reloads, even mid count
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // parks at zero until the next start
    assign running = (counter != '0);

endmodule

// ==== logic/brightness_timeout.sv ====
/* output enable window for one bit-plane, started by the row latch
   also flags the tail of the window where the next shift-out may begin */
module brightness_timeout
    import matrix_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    input  logic              row_latch,
    input  brightness_level_t brightness_mask_active,
    output logic              output_enable,
    output logic              exceeded_overlap_time
);

    logic [OE_COUNTER_WIDTH-1:0] oe_counter;
    logic [OE_COUNTER_WIDTH-1:0] oe_window;

    // mask is one-hot so its value is already the plane weight
    assign oe_window = OE_COUNTER_WIDTH'(brightness_mask_active)
                     * OE_COUNTER_WIDTH'(OE_UNIT_CYCLES);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            oe_counter <= '0;
        end else if (row_latch) begin
            // new line latched, show it for its plane weight
            oe_counter <= oe_window;
        end else if (oe_counter != '0) begin
            oe_counter <= oe_counter - 1'b1;
        end
    end

    // leds lit for the whole count, first cycle right after the latch
    assign output_enable = (oe_counter != '0);

    // last few cycles of the window
    // scan may start clocking the next line in here
    assign exceeded_overlap_time = output_enable
        && (oe_counter <= OE_COUNTER_WIDTH'(BRIGHTNESS_STATE_TIMEOUT_OVERLAP));

endmodule

// ==== logic/matrix_scan.sv ====
/* scan sequencer for the panel: column read address, gated pixel clocks,
   row latch, row addresses and the bit-plane mask, one line per state advance */
module matrix_scan
    import matrix_pkg::*;
(
    input  logic               reset,
    input  logic               clk_in,
    // column being read from the buffer, 63 down to 0
    output col_addr_t          column_address,
    // row being shifted out now
    output row_subpanel_addr_t row_address,
    // row lit on the panel, follows row_address at each latch
    output row_subpanel_addr_t row_address_active,
    output logic               clk_pixel_load,
    output logic               clk_pixel,
    output logic               row_latch,
    output logic               output_enable,
    // plane currently picked out of each pixel
    output brightness_level_t  brightness_mask
);

    // state_advance history, bit 0 newest
    logic [1:0] state;
    logic state_advance;
    logic line_start;

    // high for the 64 cycles of one line
    logic clk_pixel_load_en;
    // load window delayed to cover the buffer and shifter registers
    logic [1:0] pixel_en_delay;

    // falling edge copies, so the gated clocks have no glitches
    logic clk_pixel_load_gate;
    logic clk_pixel_en;
    // bit 0 is the pixel clock enable, bit 1 its previous value
    logic [1:0] row_latch_state;

    logic exceeded_overlap_time;

    // rising edge of state_advance starts the line
    assign line_start = (state == 2'b01);

    // 64 load cycles per line
    timeout #(
        .COUNTER_WIDTH(LOAD_COUNTER_WIDTH)
    ) timeout_clk_pixel_load_en (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (LOAD_COUNTER_WIDTH'(PIXEL_WIDTH)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column address counts 63 down to 0 in step with the load window
    // then holds at 0 until the next line
    timeout #(
        .COUNTER_WIDTH(COL_ADDR_BITS)
    ) timeout_column_address (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (col_addr_t'(PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
            pixel_en_delay <= 2'b00;
        end else begin
            state <= {state[0], state_advance};
            // two stages, one for the buffer read and one for the shifter
            pixel_en_delay <= {pixel_en_delay[0], clk_pixel_load_en};
        end
    end

    assign clk_pixel_en = row_latch_state[0];
    // latch one pulse after the pixel clock enable drops
    assign row_latch = (row_latch_state == 2'b10);

    // gated clocks, each rising edge sits on a rising edge of clk_in
    assign clk_pixel_load = clk_in && clk_pixel_load_gate;
    assign clk_pixel = clk_in && clk_pixel_en;

    // falling edge: clock enables, latch state, mask and row stepping
    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_load_gate <= 1'b0;
            row_latch_state <= 2'b00;
            brightness_mask <= BRIGHTNESS_MASK_RESET;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            clk_pixel_load_gate <= clk_pixel_load_en;
            row_latch_state <= {row_latch_state[0], pixel_en_delay[1]};
            if (row_latch) begin
                // the shifted line goes live on the panel
                row_address_active <= row_address;
                if (brightness_mask <= brightness_level_t'(1)) begin
                    // all planes of this row done, move to the next row
                    brightness_mask <= BRIGHTNESS_MASK_RESET;
                    row_address <= row_address + 1'b1;
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    // the window loads on the rising edge that sees the latch
    // the mask steps half a cycle later, so here it is still the latched line's plane
    brightness_timeout brightness_timeout_inst (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

    // next line may start once the leds are dark
    // or once the current window is in its tail
    assign state_advance = !output_enable || exceeded_overlap_time;

endmodule

// ==== logic/frame_buffer.sv ====
/* pixel memory written by the host one pixel per strobe
   read side returns the top and bottom half pixels of one column, registered */
module frame_buffer
    import matrix_pkg::*;
(
    input  logic               clk_in,
    // host write port, no back-pressure
    input  logic               wr_en,
    input  col_addr_t          wr_column,
    input  row_addr_t          wr_row,
    input  pixel_t             wr_pixel,
    // scan read port
    input  col_addr_t          rd_column,
    input  row_subpanel_addr_t rd_row,
    output pixel_t             pixel_top,
    output pixel_t             pixel_bottom
);

    // split on the top row bit so both halves read in the same cycle
    pixel_t bank_top [0:SUBPANEL_ROWS*PIXEL_WIDTH-1];
    pixel_t bank_bottom [0:SUBPANEL_ROWS*PIXEL_WIDTH-1];

    // row within the half on top, column below
    logic [$bits(row_subpanel_addr_t)+$bits(col_addr_t)-1:0] wr_addr;
    logic [$bits(row_subpanel_addr_t)+$bits(col_addr_t)-1:0] rd_addr;
    logic wr_lower_half;

    assign wr_addr = {wr_row[ROW_SUB_BITS-1:0], wr_column};
    assign wr_lower_half = wr_row[ROW_SUB_BITS];
    assign rd_addr = {rd_row, rd_column};

    // host writes, one bank per strobe
    always_ff @(posedge clk_in) begin
        if (wr_en && !wr_lower_half) begin
            bank_top[wr_addr] <= wr_pixel;
        end
        if (wr_en && wr_lower_half) begin
            bank_bottom[wr_addr] <= wr_pixel;
        end
    end

    // registered read
    // pixel_top is row rd_row, pixel_bottom is row rd_row + 16
    always_ff @(posedge clk_in) begin
        pixel_top <= bank_top[rd_addr];
        pixel_bottom <= bank_bottom[rd_addr];
    end

endmodule

// ==== logic/pixel_shifter.sv ====
/* picks the current bit-plane out of the top and bottom pixels
   and registers one bit per channel for the panel colour lines */
module pixel_shifter
    import matrix_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    input  pixel_t            pixel_top,
    input  pixel_t            pixel_bottom,
    input  brightness_level_t brightness_mask,
    output panel_rgb_t        rgb_top,
    output panel_rgb_t        rgb_bottom
);

    panel_rgb_t plane_top;
    panel_rgb_t plane_bottom;

    // a channel is on when its value has the masked bit set
    function automatic panel_rgb_t select_plane(
        input pixel_t            pixel,
        input brightness_level_t mask
    );
        panel_rgb_t bits;
        bits.red = |(pixel.red & mask);
        bits.green = |(pixel.green & mask);
        bits.blue = |(pixel.blue & mask);
        return bits;
    endfunction

    assign plane_top = select_plane(pixel_top, brightness_mask);
    assign plane_bottom = select_plane(pixel_bottom, brightness_mask);

    // one cycle behind the buffer read
    // stable by the next pixel clock edge
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_top <= '0;
            rgb_bottom <= '0;
        end else begin
            rgb_top <= plane_top;
            rgb_bottom <= plane_bottom;
        end
    end

endmodule

// ==== logic/led_matrix_top.sv ====
/* top level of the led matrix controller
   host write port in, HUB75 style panel pins out */
module led_matrix_top
    import matrix_pkg::*;
(
    input  logic               clk_in,
    input  logic               reset,
    // host pixel writes
    input  logic               wr_en,
    input  col_addr_t          wr_column,
    input  row_addr_t          wr_row,
    input  pixel_t             wr_pixel,
    // panel side
    output panel_rgb_t         rgb_top,
    output panel_rgb_t         rgb_bottom,
    output row_subpanel_addr_t row_address_active,
    output logic               clk_pixel_load,
    output logic               clk_pixel,
    output logic               row_latch,
    output logic               output_enable
);

    col_addr_t          column_address;
    row_subpanel_addr_t row_address;
    brightness_level_t  brightness_mask;
    pixel_t             pixel_top;
    pixel_t             pixel_bottom;

    frame_buffer frame_buffer_inst (
        .clk_in      (clk_in),
        .wr_en       (wr_en),
        .wr_column   (wr_column),
        .wr_row      (wr_row),
        .wr_pixel    (wr_pixel),
        .rd_column   (column_address),
        .rd_row      (row_address),
        .pixel_top   (pixel_top),
        .pixel_bottom(pixel_bottom)
    );

    matrix_scan matrix_scan_inst (
        .reset             (reset),
        .clk_in            (clk_in),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .clk_pixel_load    (clk_pixel_load),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .brightness_mask   (brightness_mask)
    );

    pixel_shifter pixel_shifter_inst (
        .clk_in         (clk_in),
        .reset          (reset),
        .pixel_top      (pixel_top),
        .pixel_bottom   (pixel_bottom),
        .brightness_mask(brightness_mask),
        .rgb_top        (rgb_top),
        .rgb_bottom     (rgb_bottom)
    );

endmodule

// ==== testbench/led_matrix_assert.sv ====
/* concurrent checks on the scan sequencer, bound into matrix_scan
   watches the latch pulse, the plane mask and the load window against the enable */
module led_matrix_assert
    import matrix_pkg::*;
(
    input logic              clk_in,
    input logic              reset,
    input logic              row_latch,
    input logic              output_enable,
    input logic              exceeded_overlap_time,
    input logic              clk_pixel_load_gate,
    input brightness_level_t brightness_mask
);

    // read by the testbench at the end of the run
    int failures = 0;

    // latch is a single clock pulse
    latch_one_cycle: assert property (@(posedge clk_in) disable iff (reset)
        row_latch |=> !row_latch)
        else begin
            failures++;
            $error("row_latch high for more than one cycle");
        end

    // exactly one plane selected at all times
    mask_one_hot: assert property (@(posedge clk_in) disable iff (reset)
        $onehot(brightness_mask))
        else begin
            failures++;
            $error("brightness_mask is not one-hot: %0h", brightness_mask);
        end

    // shifting may only overlap the tail of the enable window
    load_in_overlap: assert property (@(posedge clk_in) disable iff (reset)
        clk_pixel_load_gate && output_enable |-> exceeded_overlap_time)
        else begin
            failures++;
            $error("pixel load clock running while output_enable is outside its tail");
        end

endmodule

bind matrix_scan led_matrix_assert led_matrix_assert_inst (
    .clk_in               (clk_in),
    .reset                (reset),
    .row_latch            (row_latch),
    .output_enable        (output_enable),
    .exceeded_overlap_time(exceeded_overlap_time),
    .clk_pixel_load_gate  (clk_pixel_load_gate),
    .brightness_mask      (brightness_mask)
);

// ==== testbench/led_matrix_tb.sv ====
/* testbench for the led matrix controller: random frame from an LFSR, a frame model
   and a panel-side monitor that checks shift-out, planes, rows and enable windows */
module led_matrix_tb
    import matrix_pkg::*;
();

    localparam int LINES_PER_FRAME = SUBPANEL_ROWS * COLOR_BITS;
    // about two frames of scanning
    localparam int WAIT_LIMIT = 16000;

    logic clk_in = 1'b0;
    logic reset;
    logic wr_en;
    col_addr_t wr_column;
    row_addr_t wr_row;
    pixel_t wr_pixel;
    panel_rgb_t rgb_top;
    panel_rgb_t rgb_bottom;
    row_subpanel_addr_t row_address_active;
    logic clk_pixel_load;
    logic clk_pixel;
    logic row_latch;
    logic output_enable;

    // expected buffer contents, rows 0 to 31
    pixel_t model [0:2*SUBPANEL_ROWS-1][0:PIXEL_WIDTH-1];
    logic [31:0] lfsr_state = 32'hb2f8;
    int errors [1:6] = '{default: 0};
    int checks = 0;
    int total_errors;
    int frame_start;
    string test_names [1:6] = '{"reset values", "pulses per line", "pixel data",
        "mask and row order", "enable window", "rewritten pixels"};

    // monitor state, line_count is the index of the line now shifting
    int line_count = 0;
    int pulse_count = 0;
    int oe_length = 0;
    logic oe_before = 1'b0;
    logic data_checking = 1'b0;
    logic rows_rewritten = 1'b0;
    panel_rgb_t top_before;
    panel_rgb_t bottom_before;
    brightness_level_t window_mask;
    row_subpanel_addr_t window_row;

    led_matrix_top led_matrix_top_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .wr_en             (wr_en),
        .wr_column         (wr_column),
        .wr_row            (wr_row),
        .wr_pixel          (wr_pixel),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom),
        .row_address_active(row_address_active),
        .clk_pixel_load    (clk_pixel_load),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable)
    );

    always #5 clk_in = ~clk_in;

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // planes run 8 4 2 1, four lines per row
    function automatic brightness_level_t line_mask(input int line);
        return brightness_level_t'(1 << (COLOR_BITS - 1 - line % COLOR_BITS));
    endfunction

    // one bit per channel, taken straight from the plane's bit position
    function automatic panel_rgb_t plane_bits(input pixel_t pixel, input int plane);
        return {pixel.red[plane], pixel.green[plane], pixel.blue[plane]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic compare_value(input int test, input string name,
                                 input logic [31:0] actual, input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors[test]++;
            $display("Error: %s = %0h, expected %0h (test %0d, line %0d)",
                     name, actual, expected, test, line_count);
        end
    endtask

    // one random pixel per clock, mirrored into the model
    task automatic write_pixel(input int row, input int column);
        logic [31:0] bits;
        draw_bits($bits(pixel_t), bits);
        @(posedge clk_in);
        wr_en <= 1'b1;
        wr_row <= row_addr_t'(row);
        wr_column <= col_addr_t'(column);
        wr_pixel <= bits[$bits(pixel_t)-1:0];
        model[row][column] = bits[$bits(pixel_t)-1:0];
    endtask

    task automatic wait_lines(input int test, input int target);
        int cycles;
        cycles = 0;
        while (line_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clk_in);
            cycles++;
        end
        if (line_count < target) begin
            errors[test]++;
            $display("test %0d: scan stalled, no row latch for %0d cycles", test, WAIT_LIMIT);
        end
    endtask

    // data the panel takes at a pixel clock edge, column 63 first
    task automatic check_pulse(input int column);
        int row;
        int plane;
        int test;
        row = (line_count / COLOR_BITS) % SUBPANEL_ROWS;
        plane = COLOR_BITS - 1 - line_count % COLOR_BITS;
        test = (rows_rewritten && row == 0) ? 6 : 3;
        compare_value(test, "rgb_top", top_before, plane_bits(model[row][column], plane));
        compare_value(test, "rgb_bottom", bottom_before,
                      plane_bits(model[row + SUBPANEL_ROWS][column], plane));
    endtask

    // panel-side monitor, sampled mid high phase
    // colour lines kept from before the edge, that is what the panel shifts in
    always begin
        top_before = rgb_top;
        bottom_before = rgb_bottom;
        @(posedge clk_in);
        #2;
        if (!reset) begin
            if (clk_pixel === 1'b1) begin
                if (data_checking && pulse_count < PIXEL_WIDTH) begin
                    check_pulse(PIXEL_WIDTH - 1 - pulse_count);
                end
                pulse_count++;
            end
            if (row_latch === 1'b1) begin
                compare_value(2, "clk_pixel pulses", pulse_count, PIXEL_WIDTH);
                compare_value(4, "brightness_mask", led_matrix_top_inst.brightness_mask,
                              line_mask(line_count));
                window_mask = line_mask(line_count);
                window_row = row_subpanel_addr_t'((line_count / COLOR_BITS) % SUBPANEL_ROWS);
                pulse_count = 0;
                line_count++;
            end
            // window starts with the latch edge itself
            if (output_enable === 1'b1) begin
                oe_length++;
            end else if (oe_before) begin
                compare_value(5, "output_enable cycles", oe_length, OE_UNIT_CYCLES * window_mask);
                compare_value(4, "row_address_active", row_address_active, window_row);
                oe_length = 0;
            end
            oe_before = (output_enable === 1'b1);
        end
    end

    initial begin
        reset <= 1'b1;
        wr_en <= 1'b0;
        wr_column <= '0;
        wr_row <= '0;
        wr_pixel <= '0;
        repeat (4) @(posedge clk_in);
        reset <= 1'b0;
        #2;
        compare_value(1, "output_enable", output_enable, 0);
        compare_value(1, "row_latch", row_latch, 0);
        compare_value(1, "clk_pixel_load", clk_pixel_load, 0);
        compare_value(1, "rgb_top", rgb_top, 0);
        compare_value(1, "rgb_bottom", rgb_bottom, 0);
        $display("test 1 %s: %0d errors", test_names[1], errors[1]);

        // whole frame, both halves, while the first frame scans
        for (int row = 0; row < 2 * SUBPANEL_ROWS; row++) begin
            for (int column = 0; column < PIXEL_WIDTH; column++) begin
                write_pixel(row, column);
            end
        end
        @(posedge clk_in);
        wr_en <= 1'b0;

        // compare data from the next frame boundary on
        frame_start = (line_count / LINES_PER_FRAME + 1) * LINES_PER_FRAME;
        wait_lines(3, frame_start);
        data_checking = 1'b1;

        // row 0 is done for this frame once row 1 starts
        wait_lines(6, frame_start + COLOR_BITS);
        for (int column = 0; column < PIXEL_WIDTH; column++) begin
            write_pixel(0, column);
            write_pixel(SUBPANEL_ROWS, column);
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
        rows_rewritten = 1'b1;
        wait_lines(6, frame_start + 2 * LINES_PER_FRAME);

        total_errors = led_matrix_top_inst.matrix_scan_inst.led_matrix_assert_inst.failures;
        for (int test = 2; test <= 6; test++) begin
            $display("test %0d %s: %0d errors", test, test_names[test], errors[test]);
        end
        for (int test = 1; test <= 6; test++) begin
            total_errors += errors[test];
        end
        $display("lines %0d, checks %0d, errors %0d", line_count, checks, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/matrix_pkg.sv
logic/timeout.sv
logic/brightness_timeout.sv
logic/matrix_scan.sv
logic/frame_buffer.sv
logic/pixel_shifter.sv
logic/led_matrix_top.sv
testbench/led_matrix_assert.sv
testbench/led_matrix_tb.sv

// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - logic/matrix_pkg.sv
  - logic/timeout.sv
  - logic/brightness_timeout.sv
  - logic/matrix_scan.sv
  - logic/frame_buffer.sv
  - logic/pixel_shifter.sv
  - logic/led_matrix_top.sv
  - target: simulation
    files:
      - testbench/led_matrix_assert.sv
      - testbench/led_matrix_tb.sv
